/* include/dma_params.svh */
`ifndef DMA_PARAMS_SVH
`define DMA_PARAMS_SVH

// bus and register widths
`define DMA_ADDR_W 32
`define DMA_DATA_W 32
`define DMA_COUNT_W 14
`define DMA_CTRL_W 16

`define DMA_NUM_CH 2

// control word fields
`define DMA_DSTMODE_LSB 5 // bits 6..5
`define DMA_SRCMODE_LSB 7 // bits 8..7
`define DMA_WORD_BIT 10
`define DMA_IRQ_BIT 14

`endif

/* hw/dmaBusPkg.sv */
`default_nettype none

`include "dma_params.svh"

package dmaBusPkg;

  typedef logic [`DMA_ADDR_W-1:0] addr_t;
  typedef logic [`DMA_DATA_W-1:0] data_t;

  // 1 = halfword, 2 = word
  typedef logic [1:0] size_t;

  // units left to move, 0 stands for 16384
  typedef logic [`DMA_COUNT_W-1:0] count_t;

endpackage

`default_nettype wire

/* hw/dmaCtrlPkg.sv */
`default_nettype none

`include "dma_params.svh"

package dmaCtrlPkg;

  // raw control word as seen at the config port
  typedef logic [`DMA_CTRL_W-1:0] ctrl_t;

  // per-side address stepping, code 3 steps up like code 0
  typedef enum logic [1:0] {
    stepInc    = 2'd0,
    stepDec    = 2'd1,
    stepFixed  = 2'd2,
    stepIncAlt = 2'd3
  } stepMode_t;

  typedef enum logic [1:0] {
    seqOff    = 2'd0,
    seqQueued = 2'd1, // waiting for the bus
    seqRead   = 2'd2,
    seqWrite  = 2'd3
  } seqState_t;

endpackage

`default_nettype wire

/* hw/dmaChannelIf.sv */
`timescale 1ns/100ps
`default_nettype none

interface dmaChannelIf (
  input logic clk,
  input logic rst_b
);
  import dmaBusPkg::*;

  logic  busReq; // wants the bus for the next unit
  logic  grant;
  logic  active; // in a read or write cycle
  logic  write;
  addr_t addr;
  data_t wdata;
  size_t size;

  modport channel (
    input  clk, rst_b, grant,
    output busReq, active, write, addr, wdata, size
  );

  modport arbiter (
    input  clk, rst_b, busReq, active, write, addr, wdata, size,
    output grant
  );

endinterface

`default_nettype wire

/* hw/dmaSequencer.sv */
`timescale 1ns/100ps
`default_nettype none

module dmaSequencer (
  input  logic clk,
  input  logic rst_b,
  input  logic accept,
  input  logic grant,
  input  logic memWait,
  input  logic lastUnit,
  input  logic irqEn,
  output logic busReq,
  output logic active,
  output logic write,
  output logic loadRegs,
  output logic stepSrc,
  output logic stepDst,
  output logic captureData,
  output logic irq,
  output logic idle
);
  import dmaCtrlPkg::*;

  seqState_t state, nextState;

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      state <= seqOff;
    end else begin
      state <= nextState;
    end
  end

  always_comb begin
    nextState   = state;
    busReq      = 1'b0;
    active      = 1'b0;
    write       = 1'b0;
    loadRegs    = 1'b0;
    stepSrc     = 1'b0;
    stepDst     = 1'b0;
    captureData = 1'b0;
    irq         = 1'b0;
    idle        = 1'b0;
    case (state)
      seqOff: begin
        idle = 1'b1;
        if (accept) begin
          loadRegs  = 1'b1;
          nextState = seqQueued;
        end
      end
      seqQueued: begin
        busReq = 1'b1;
        if (grant && !memWait) begin
          nextState = seqRead;
        end
      end
      seqRead: begin
        active = 1'b1;
        if (!memWait) begin
          captureData = 1'b1; // read data valid on this edge
          stepSrc     = 1'b1;
          nextState   = seqWrite;
        end
      end
      seqWrite: begin
        active = 1'b1;
        write  = 1'b1;
        busReq = !lastUnit; // ask to keep the bus for the next pair
        if (!memWait) begin
          stepDst = 1'b1;
          if (lastUnit) begin
            irq       = irqEn;
            nextState = seqOff;
          end else if (grant) begin
            nextState = seqRead;
          end else begin
            nextState = seqQueued; // higher priority channel takes over here
          end
        end
      end
      default: nextState = seqOff;
    endcase
  end

  // a read cycle only ever starts from a granted request
  assert property (@(posedge clk) disable iff (!rst_b)
    (state == seqRead && $past(state) != seqRead) |-> $past(grant));

endmodule

`default_nettype wire

/* hw/dmaAddressPath.sv */
`timescale 1ns/100ps
`default_nettype none

`include "dma_params.svh"

module dmaAddressPath (
  input  logic              clk,
  input  logic              rst_b,
  input  logic              loadRegs,
  input  logic              stepSrc,
  input  logic              stepDst,
  input  logic              captureData,
  input  logic              write,
  input  dmaBusPkg::addr_t  cfgSrc,
  input  dmaBusPkg::addr_t  cfgDst,
  input  dmaBusPkg::count_t cfgCount,
  input  dmaCtrlPkg::ctrl_t cfgCtrl,
  input  dmaBusPkg::data_t  memRdata,
  output dmaBusPkg::addr_t  addr,
  output dmaBusPkg::data_t  wdata,
  output dmaBusPkg::size_t  size,
  output logic              lastUnit,
  output logic              irqEn
);
  import dmaBusPkg::*;
  import dmaCtrlPkg::*;

  addr_t     srcAddr;
  addr_t     dstAddr;
  addr_t     unitStep;
  count_t    remaining;
  ctrl_t     ctrl;
  data_t     dataReg;
  logic      wordUnit;
  stepMode_t srcMode;
  stepMode_t dstMode;

  function automatic addr_t stepAddr(addr_t cur, stepMode_t mode, addr_t delta);
    case (mode)
      stepDec:   return cur - delta;
      stepFixed: return cur;
      default:   return cur + delta;
    endcase
  endfunction

  assign wordUnit = ctrl[`DMA_WORD_BIT];
  assign srcMode  = stepMode_t'(ctrl[`DMA_SRCMODE_LSB +: 2]);
  assign dstMode  = stepMode_t'(ctrl[`DMA_DSTMODE_LSB +: 2]);
  assign unitStep = wordUnit ? addr_t'(4) : addr_t'(2);
  assign irqEn    = ctrl[`DMA_IRQ_BIT];

  // a loaded zero wraps through the full range, giving 16384 units
  assign lastUnit = (remaining == count_t'(1));

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      ctrl      <= '0;
      remaining <= '0;
    end else if (loadRegs) begin
      ctrl      <= cfgCtrl;
      remaining <= cfgCount;
    end else if (stepDst) begin
      remaining <= remaining - count_t'(1);
    end
  end

  always_ff @(posedge clk) begin
    if (loadRegs) begin
      srcAddr <= cfgSrc;
      dstAddr <= cfgDst;
    end else begin
      if (stepSrc) srcAddr <= stepAddr(srcAddr, srcMode, unitStep);
      if (stepDst) dstAddr <= stepAddr(dstAddr, dstMode, unitStep);
    end
    if (captureData) dataReg <= memRdata;
  end

  assign addr = write ? dstAddr : srcAddr;
  assign size = wordUnit ? size_t'(2) : size_t'(1);

  always_comb begin
    wdata = dataReg;
    if (!wordUnit && dstAddr[1]) begin
      wdata[`DMA_DATA_W-1 -: 16] = dataReg[15:0]; // halfword to upper lane
    end
  end

endmodule

`default_nettype wire

/* hw/dmaChannel.sv */
`timescale 1ns/100ps
`default_nettype none

module dmaChannel (
  input  logic              clk,
  input  logic              rst_b,
  input  logic              cfgValid,
  output logic              cfgReady,
  input  dmaBusPkg::addr_t  cfgSrc,
  input  dmaBusPkg::addr_t  cfgDst,
  input  dmaBusPkg::count_t cfgCount,
  input  dmaCtrlPkg::ctrl_t cfgCtrl,
  input  dmaBusPkg::data_t  memRdata,
  input  logic              memWait,
  output logic              irq,
  dmaChannelIf.channel      bus
);
  import dmaBusPkg::*;

  logic  accept, idle;
  logic  loadRegs, stepSrc, stepDst, captureData;
  logic  lastUnit, irqEn;
  logic  busReq, active, write;
  addr_t addr;
  data_t wdata;
  size_t size;

  // config is taken only while the sequencer sits in off
  assign cfgReady = idle;
  assign accept   = cfgValid && idle;

  dmaSequencer seq (
    .clk, .rst_b, .accept, .grant(bus.grant), .memWait, .lastUnit, .irqEn,
    .busReq, .active, .write, .loadRegs, .stepSrc, .stepDst, .captureData,
    .irq, .idle
  );

  dmaAddressPath path (
    .clk, .rst_b, .loadRegs, .stepSrc, .stepDst, .captureData, .write,
    .cfgSrc, .cfgDst, .cfgCount, .cfgCtrl, .memRdata,
    .addr, .wdata, .size, .lastUnit, .irqEn
  );

  assign bus.busReq = busReq;
  assign bus.active = active;
  assign bus.write  = write;
  assign bus.addr   = addr;
  assign bus.wdata  = wdata;
  assign bus.size   = size;

endmodule

`default_nettype wire

/* hw/dmaArbiter.sv */
`timescale 1ns/100ps
`default_nettype none

`include "dma_params.svh"

module dmaArbiter (
  dmaChannelIf.arbiter     ch0,
  dmaChannelIf.arbiter     ch1,
  output logic             memActive,
  output logic             memWrite,
  output dmaBusPkg::addr_t memAddr,
  output dmaBusPkg::data_t memWdata,
  output dmaBusPkg::size_t memSize
);
  logic [`DMA_NUM_CH-1:0] req, act, grantVec;

  assign req = {ch1.busReq, ch0.busReq};
  assign act = {ch1.active, ch0.active};

  // lower index wins, and nobody starts while another channel holds the bus
  always_comb begin
    logic higherReq;
    logic othersActive;
    higherReq = 1'b0;
    for (int i = 0; i < `DMA_NUM_CH; i++) begin
      othersActive = 1'b0;
      for (int j = 0; j < `DMA_NUM_CH; j++) begin
        if (j != i) othersActive = othersActive | act[j];
      end
      grantVec[i] = req[i] && !higherReq && !othersActive;
      higherReq   = higherReq | req[i];
    end
  end

  assign ch0.grant = grantVec[0];
  assign ch1.grant = grantVec[1];

  assign memActive = |act;
  assign memWrite  = (ch0.active && ch0.write) || (ch1.active && ch1.write);
  assign memAddr   = ch1.active ? ch1.addr : ch0.addr;
  assign memWdata  = ch1.active ? ch1.wdata : ch0.wdata;
  assign memSize   = ch1.active ? ch1.size : ch0.size;

  assert property (@(posedge ch0.clk) disable iff (!ch0.rst_b)
    !(ch0.active && ch1.active));

  assert property (@(posedge ch0.clk) disable iff (!ch0.rst_b)
    !(ch0.grant && ch1.grant));

endmodule

`default_nettype wire

/* hw/dmaTop.sv */
`timescale 1ns/100ps
`default_nettype none

module dmaTop (
  input  logic              clk,
  input  logic              rst_b,
  // channel 0 config
  input  logic              cfgValid0,
  output logic              cfgReady0,
  input  dmaBusPkg::addr_t  cfgSrc0,
  input  dmaBusPkg::addr_t  cfgDst0,
  input  dmaBusPkg::count_t cfgCount0,
  input  dmaCtrlPkg::ctrl_t cfgCtrl0,
  // channel 1 config
  input  logic              cfgValid1,
  output logic              cfgReady1,
  input  dmaBusPkg::addr_t  cfgSrc1,
  input  dmaBusPkg::addr_t  cfgDst1,
  input  dmaBusPkg::count_t cfgCount1,
  input  dmaCtrlPkg::ctrl_t cfgCtrl1,
  // memory bus
  input  dmaBusPkg::data_t  memRdata,
  input  logic              memWait,
  output logic              memActive,
  output logic              memWrite,
  output dmaBusPkg::addr_t  memAddr,
  output dmaBusPkg::data_t  memWdata,
  output dmaBusPkg::size_t  memSize,
  output logic              irq0,
  output logic              irq1
);

  dmaChannelIf bus0 (.clk, .rst_b);
  dmaChannelIf bus1 (.clk, .rst_b);

  dmaChannel ch0 (
    .clk, .rst_b,
    .cfgValid(cfgValid0), .cfgReady(cfgReady0),
    .cfgSrc(cfgSrc0), .cfgDst(cfgDst0), .cfgCount(cfgCount0), .cfgCtrl(cfgCtrl0),
    .memRdata, .memWait,
    .irq(irq0),
    .bus(bus0.channel)
  );

  dmaChannel ch1 (
    .clk, .rst_b,
    .cfgValid(cfgValid1), .cfgReady(cfgReady1),
    .cfgSrc(cfgSrc1), .cfgDst(cfgDst1), .cfgCount(cfgCount1), .cfgCtrl(cfgCtrl1),
    .memRdata, .memWait,
    .irq(irq1),
    .bus(bus1.channel)
  );

  // channel 0 has priority
  dmaArbiter arb (
    .ch0(bus0.arbiter),
    .ch1(bus1.arbiter),
    .memActive, .memWrite, .memAddr, .memWdata, .memSize
  );

endmodule

`default_nettype wire

/* testbench/dmaMemModel.sv */
`timescale 1ns/100ps
`default_nettype none

module dmaMemModel (
  input  logic             clk,
  input  logic             rst_b,
  input  logic             waitEn,
  input  dmaBusPkg::data_t rdKey,
  input  logic             memActive,
  input  logic             memWrite,
  input  dmaBusPkg::addr_t memAddr,
  input  dmaBusPkg::data_t memWdata,
  input  dmaBusPkg::size_t memSize,
  output dmaBusPkg::data_t memRdata,
  output logic             memWait
);
  import dmaBusPkg::*;

  localparam int LOG_DEPTH = 256;

  logic [31:0] lcgState;
  addr_t       logAddr [LOG_DEPTH];
  data_t       logData [LOG_DEPTH];
  size_t       logSize [LOG_DEPTH];
  int          logCount;

  function automatic logic [31:0] lcgNext(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // read data depends on the whole address
  assign memRdata = memAddr ^ rdKey;

  always @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      lcgState <= 32'd67245;
      memWait  <= 1'b0;
      logCount <= 0;
    end else begin
      if (memActive && memWrite && !memWait && logCount < LOG_DEPTH) begin
        logAddr[logCount] <= memAddr; // completed write
        logData[logCount] <= memWdata;
        logSize[logCount] <= memSize;
        logCount          <= logCount + 1;
      end
      lcgState <= lcgNext(lcgState);
      memWait  <= waitEn && lcgState[16]; // stalls about half the cycles
    end
  end

endmodule

`default_nettype wire

/* testbench/dmaTb.sv */
`timescale 1ns/100ps
`default_nettype none

`include "dma_params.svh"

module dmaTb;
  import dmaBusPkg::*;
  import dmaCtrlPkg::*;

  localparam int    NUM_ROWS = 6;
  localparam data_t RD_KEY   = 32'h5A3C_96E1;

  typedef struct packed {
    logic       en;
    addr_t      src;
    addr_t      dst;
    count_t     cnt;
    ctrl_t      ctrl;
    logic [7:0] delay; // cycles from row start to cfgValid
  } chanCfg_t;

  logic     clk, rst_b, waitEn;
  logic     cfgValid0, cfgValid1, cfgReady0, cfgReady1;
  addr_t    cfgSrc0, cfgSrc1, cfgDst0, cfgDst1, memAddr;
  count_t   cfgCount0, cfgCount1;
  ctrl_t    cfgCtrl0, cfgCtrl1;
  data_t    memRdata, memWdata;
  size_t    memSize;
  logic     memWait, memActive, memWrite, irq0, irq1;
  chanCfg_t cfgTab [NUM_ROWS][2];
  logic     waitTab [NUM_ROWS];
  logic     splitTab [NUM_ROWS];
  int       errors, testsRun, testsFailed, limit, irqCount0, irqCount1;

  dmaTop DUT (
    .clk, .rst_b,
    .cfgValid0, .cfgReady0, .cfgSrc0, .cfgDst0, .cfgCount0, .cfgCtrl0,
    .cfgValid1, .cfgReady1, .cfgSrc1, .cfgDst1, .cfgCount1, .cfgCtrl1,
    .memRdata, .memWait, .memActive, .memWrite, .memAddr, .memWdata, .memSize,
    .irq0, .irq1
  );

  dmaMemModel mem (
    .clk, .rst_b, .waitEn, .rdKey(RD_KEY),
    .memActive, .memWrite, .memAddr, .memWdata, .memSize, .memRdata, .memWait
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      irqCount0 <= 0;
      irqCount1 <= 0;
    end else begin
      if (irq0) irqCount0 <= irqCount0 + 1;
      if (irq1) irqCount1 <= irqCount1 + 1;
    end
  end

  function automatic chanCfg_t makeCfg(input addr_t src, input addr_t dst, input count_t cnt,
                                       input ctrl_t ctrl, input logic [7:0] delay);
    return '{1'b1, src, dst, cnt, ctrl, delay};
  endfunction

  // address of unit k, codes 0 and 3 both count up
  function automatic addr_t stepAt(input addr_t base, input logic [1:0] mode,
                                   input logic word, input int k);
    addr_t delta;
    delta = addr_t'(k) * (word ? addr_t'(4) : addr_t'(2));
    if (mode == 2'd1) return base - delta;
    if (mode == 2'd2) return base;
    return base + delta;
  endfunction

  function automatic addr_t dstAt(input chanCfg_t c, input int k);
    return stepAt(c.dst, c.ctrl[`DMA_DSTMODE_LSB +: 2], c.ctrl[`DMA_WORD_BIT], k);
  endfunction

  function automatic addr_t srcAt(input chanCfg_t c, input int k);
    return stepAt(c.src, c.ctrl[`DMA_SRCMODE_LSB +: 2], c.ctrl[`DMA_WORD_BIT], k);
  endfunction

  task automatic fillTable();
    for (int r = 0; r < NUM_ROWS; r++) begin
      cfgTab[r][0] = '0;
      cfgTab[r][1] = '0;
      waitTab[r]   = 1'b0;
      splitTab[r]  = 1'b0;
    end
    // word copies, increment on both sides, irq on and off
    cfgTab[0][0] = makeCfg(32'h0000_1000, 32'h0000_8000, 14'd6, 16'h4400, 8'd1);
    cfgTab[1][0] = makeCfg(32'h0000_1100, 32'h0000_8100, 14'd3, 16'h0400, 8'd0);
    // halfwords, source down, destination fixed in the upper lane
    cfgTab[2][0] = makeCfg(32'h0000_2040, 32'h0000_9002, 14'd5, 16'h40C0, 8'd0);
    cfgTab[3][0] = makeCfg(32'h0000_2100, 32'h0000_9100, 14'd4, 16'h0000, 8'd2);
    // random stalls on both channels
    cfgTab[4][0] = makeCfg(32'h0000_3000, 32'h0000_A000, 14'd8, 16'h4400, 8'd0);
    cfgTab[4][1] = makeCfg(32'h0000_3800, 32'h0000_B002, 14'd5, 16'h4020, 8'd3);
    waitTab[4]   = 1'b1;
    // channel 0 cuts into a long channel 1 transfer
    cfgTab[5][0] = makeCfg(32'h0000_5000, 32'h0000_D000, 14'd4, 16'h4400, 8'd12);
    cfgTab[5][1] = makeCfg(32'h0000_4000, 32'h0000_C000, 14'd20, 16'h4400, 8'd0);
    splitTab[5]  = 1'b1;
  endtask

  task automatic startCh0(input chanCfg_t c);
    repeat (int'(c.delay) + 1) @(posedge clk);
    cfgValid0 <= 1'b1;
    cfgSrc0   <= c.src;
    cfgDst0   <= c.dst;
    cfgCount0 <= c.cnt;
    cfgCtrl0  <= c.ctrl;
    @(negedge clk);
    while (!cfgReady0) @(negedge clk);
    @(posedge clk); // accepted on this edge
    cfgValid0 <= 1'b0;
  endtask

  task automatic startCh1(input chanCfg_t c);
    repeat (int'(c.delay) + 1) @(posedge clk);
    cfgValid1 <= 1'b1;
    cfgSrc1   <= c.src;
    cfgDst1   <= c.dst;
    cfgCount1 <= c.cnt;
    cfgCtrl1  <= c.ctrl;
    @(negedge clk);
    while (!cfgReady1) @(negedge clk);
    @(posedge clk);
    cfgValid1 <= 1'b0;
  endtask

  task automatic checkReset();
    assert (cfgReady0 && cfgReady1) else begin
      $display("ERR cfgReady0/cfgReady1 got %h/%h expected 1/1", cfgReady0, cfgReady1);
      errors++;
    end
    assert (!memActive && !memWrite) else begin
      $display("ERR memActive/memWrite got %h/%h expected 0/0", memActive, memWrite);
      errors++;
    end
    assert (!irq0 && !irq1) else begin
      $display("ERR irq0/irq1 got %h/%h expected 0/0", irq0, irq1);
      errors++;
    end
  endtask

  task automatic checkWrite(input int ch, input chanCfg_t c, input int k, input int i);
    data_t rd;
    addr_t d;
    size_t sz;
    logic  word;
    word = c.ctrl[`DMA_WORD_BIT];
    sz   = word ? size_t'(2) : size_t'(1);
    rd   = srcAt(c, k) ^ RD_KEY;
    d    = dstAt(c, k);
    assert (mem.logSize[i] == sz) else begin
      $display("ERR memSize ch%0d unit %0d got %h expected %h", ch, k, mem.logSize[i], sz);
      errors++;
    end
    if (word) begin
      assert (mem.logData[i] == rd) else begin
        $display("ERR memWdata ch%0d unit %0d got %h expected %h", ch, k, mem.logData[i], rd);
        errors++;
      end
    end else if (d[1]) begin
      assert (mem.logData[i][31:16] == rd[15:0]) else begin
        $display("ERR memWdata[31:16] ch%0d unit %0d got %h expected %h",
                 ch, k, mem.logData[i][31:16], rd[15:0]);
        errors++;
      end
    end else begin
      assert (mem.logData[i][15:0] == rd[15:0]) else begin
        $display("ERR memWdata[15:0] ch%0d unit %0d got %h expected %h",
                 ch, k, mem.logData[i][15:0], rd[15:0]);
        errors++;
      end
    end
  endtask

  task automatic checkRow(input int r, input int logBase, input int irqBase0, input int irqBase1);
    chanCfg_t c0, c1;
    int       p0, p1, owner, prevOwner, firstOwner, runs0, exp0, exp1, irqExp0, irqExp1;
    c0 = cfgTab[r][0];
    c1 = cfgTab[r][1];
    p0 = 0;
    p1 = 0;
    owner = -1;
    prevOwner = -1;
    firstOwner = -1;
    runs0 = 0;
    exp0 = c0.en ? int'(c0.cnt) : 0;
    exp1 = c1.en ? int'(c1.cnt) : 0;
    irqExp0 = int'(c0.en && c0.ctrl[`DMA_IRQ_BIT]);
    irqExp1 = int'(c1.en && c1.ctrl[`DMA_IRQ_BIT]);
    assert (irqCount0 - irqBase0 == irqExp0) else begin
      $display("ERR irq0 pulses got %h expected %h", irqCount0 - irqBase0, irqExp0);
      errors++;
    end
    assert (irqCount1 - irqBase1 == irqExp1) else begin
      $display("ERR irq1 pulses got %h expected %h", irqCount1 - irqBase1, irqExp1);
      errors++;
    end
    for (int i = logBase; i < mem.logCount; i++) begin
      if (p0 < exp0 && mem.logAddr[i] == dstAt(c0, p0)) begin
        checkWrite(0, c0, p0, i);
        owner = 0;
        p0++;
      end else if (p1 < exp1 && mem.logAddr[i] == dstAt(c1, p1)) begin
        checkWrite(1, c1, p1, i);
        owner = 1;
        p1++;
      end else begin
        owner = -1;
        assert (1'b0) else begin
          $display("ERR memAddr got %h expected %h or %h",
                   mem.logAddr[i], dstAt(c0, p0), dstAt(c1, p1));
          errors++;
        end
      end
      if (owner == 0 && prevOwner != 0) runs0++;
      if (i == logBase) firstOwner = owner;
      prevOwner = owner;
    end
    assert (p0 == exp0 && p1 == exp1) else begin
      $display("units missing: channel 0 wrote %0d of %0d, channel 1 wrote %0d of %0d",
               p0, exp0, p1, exp1);
      errors++;
    end
    if (splitTab[r]) begin
      assert (runs0 == 1 && firstOwner == 1 && prevOwner == 1) else begin
        $display("channel 0 writes were not one run inside the channel 1 transfer");
        errors++;
      end
    end
  endtask

  task automatic reportTest(input string name, input int errBefore);
    testsRun++;
    if (errors != errBefore) testsFailed++;
    $display("%s: %s", name, (errors == errBefore) ? "passed" : "failed");
  endtask

  initial begin : watchdog
    int cycles;
    cycles = 0;
    wait (limit > 0);
    while (cycles < limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout after %0d cycles, a transfer never finished", cycles);
    $display("Test FAILED");
    $finish;
  end

  initial begin
    int errBefore, logBase, irqBase0, irqBase1, units;
    rst_b = 1'b0;
    waitEn = 1'b0;
    cfgValid0 = 1'b0;
    cfgValid1 = 1'b0;
    cfgSrc0 = '0;
    cfgSrc1 = '0;
    cfgDst0 = '0;
    cfgDst1 = '0;
    cfgCount0 = '0;
    cfgCount1 = '0;
    cfgCtrl0 = '0;
    cfgCtrl1 = '0;
    errors = 0;
    testsRun = 0;
    testsFailed = 0;
    fillTable();
    units = 0;
    for (int r = 0; r < NUM_ROWS; r++) begin
      units += 2 * (int'(cfgTab[r][0].cnt) + int'(cfgTab[r][1].cnt)) * 4;
    end
    limit = 4 * units + 100;

    repeat (4) @(posedge clk);
    rst_b <= 1'b1;
    @(negedge clk);
    errBefore = errors;
    checkReset();
    reportTest("reset state", errBefore);

    for (int r = 0; r < NUM_ROWS; r++) begin
      errBefore = errors;
      logBase = mem.logCount;
      irqBase0 = irqCount0;
      irqBase1 = irqCount1;
      @(posedge clk);
      waitEn <= waitTab[r];
      fork
        begin
          if (cfgTab[r][0].en) startCh0(cfgTab[r][0]);
        end
        begin
          if (cfgTab[r][1].en) startCh1(cfgTab[r][1]);
        end
      join
      do @(negedge clk); while (!(cfgReady0 && cfgReady1 && !memActive));
      checkRow(r, logBase, irqBase0, irqBase1);
      reportTest($sformatf("row %0d, %0d writes", r, mem.logCount - logBase), errBefore);
    end

    $display("%0d tests run, %0d failed, %0d errors", testsRun, testsFailed, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* dmaTwoCh.f */
+incdir+include
hw/dmaBusPkg.sv
hw/dmaCtrlPkg.sv
hw/dmaChannelIf.sv
hw/dmaSequencer.sv
hw/dmaAddressPath.sv
hw/dmaChannel.sv
hw/dmaArbiter.sv
hw/dmaTop.sv
testbench/dmaMemModel.sv
testbench/dmaTb.sv

/* run.sh */
#!/bin/sh
# build and run the two-channel DMA testbench with Verilator
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal -f dmaTwoCh.f \
    --top-module dmaTb -o dmaSim; then
  echo "verilator build failed"
  exit 1
fi

if ! ./obj_dir/dmaSim > sim.log 2>&1; then
  cat sim.log
  echo "simulation exited with an error status"
  exit 1
fi
cat sim.log

if grep -qx "Test OK" sim.log; then
  exit 0
fi
echo "pass message not found in sim.log"
exit 1
